// File: design/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   bus_en_i,
    input  platform_pkg::byte_en_t bus_we_i,
    input  platform_pkg::addr_t    bus_addr_i,
    input  platform_pkg::word_t    bus_wdata_i,
    output platform_pkg::word_t    bus_rdata_o,
    data_bus_if.master             ram_bus,
    data_bus_if.master             rtc_bus,
    data_bus_if.master             plic_bus
);

    platform_pkg::region_e region, region_q;
    logic                  rd;

    //////////////////////////////
    // address decode
    //////////////////////////////
    always_comb begin
        if (bus_addr_i[31:28] < platform_pkg::RTC_REGION_START) begin
            region = platform_pkg::RAM;
        end else if (bus_addr_i[31:28] < platform_pkg::PLIC_REGION_START) begin
            region = platform_pkg::RTC;
        end else if (bus_addr_i[31:28] < platform_pkg::PERIPH_REGION_START) begin
            region = platform_pkg::PLIC;
        end else begin
            region = platform_pkg::PERIPH; // decoded, nobody answers
        end
    end

    assign rd = bus_en_i && (bus_we_i == '0);

    assign ram_bus.en  = bus_en_i && (region == platform_pkg::RAM);
    assign rtc_bus.en  = bus_en_i && (region == platform_pkg::RTC);
    assign plic_bus.en = bus_en_i && (region == platform_pkg::PLIC);

    // shared by all slaves
    assign ram_bus.we     = bus_we_i;
    assign ram_bus.addr   = bus_addr_i;
    assign ram_bus.wdata  = bus_wdata_i;
    assign rtc_bus.we     = bus_we_i;
    assign rtc_bus.addr   = bus_addr_i;
    assign rtc_bus.wdata  = bus_wdata_i;
    assign plic_bus.we    = bus_we_i;
    assign plic_bus.addr  = bus_addr_i;
    assign plic_bus.wdata = bus_wdata_i;

    //////////////////////////////
    // read return path
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            region_q <= platform_pkg::NONE;
        end else begin
            region_q <= rd ? region : platform_pkg::NONE;
        end
    end

    always_comb begin
        case (region_q)
            platform_pkg::RAM:  bus_rdata_o = ram_bus.rdata;
            platform_pkg::RTC:  bus_rdata_o = rtc_bus.rdata;
            platform_pkg::PLIC: bus_rdata_o = plic_bus.rdata;
            default:            bus_rdata_o = '0; // periph or idle
        endcase
    end

endmodule

// File: design/data_bus_if.sv
`timescale 1ns/1ps

interface data_bus_if;

    logic                   en;     // transfer this cycle
    platform_pkg::byte_en_t we;     // zero means read
    platform_pkg::addr_t    addr;
    platform_pkg::word_t    wdata;
    platform_pkg::word_t    rdata;  // valid one cycle after en

    modport master (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// File: design/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic      clk,
    data_bus_if.slave bus
);

    localparam int ADDR_W = $clog2(RAM_WORDS);

    platform_pkg::word_t mem [RAM_WORDS];
    logic [ADDR_W-1:0]   idx;

    // word index, upper address bits wrap
    assign idx = bus.addr[ADDR_W+1:2];

    //////////////////////////////
    // byte-lane write, registered read
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (bus.en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.we[lane]) begin
                    mem[idx][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
                end
            end
            bus.rdata <= mem[idx]; // old word on a write cycle
        end
    end

endmodule

// File: design/platform_pkg.sv
package platform_pkg;

    typedef logic [31:0] word_t;    // bus data word
    typedef logic [31:0] addr_t;    // byte address
    typedef logic [3:0]  byte_en_t; // one bit per byte lane

    typedef enum logic [2:0] {
        RAM,
        RTC,
        PLIC,
        PERIPH,
        NONE
    } region_e;

    // top nibble of the address where each region begins, RAM below
    localparam logic [3:0] RTC_REGION_START    = 4'h2;
    localparam logic [3:0] PLIC_REGION_START   = 4'h3;
    localparam logic [3:0] PERIPH_REGION_START = 4'h8;

    localparam logic [3:0] RTC_MTIME_LO    = 4'h0;
    localparam logic [3:0] RTC_MTIME_HI    = 4'h4;
    localparam logic [3:0] RTC_MTIMECMP_LO = 4'h8;
    localparam logic [3:0] RTC_MTIMECMP_HI = 4'hc;

    localparam logic [3:0] PLIC_PENDING = 4'h0;
    localparam logic [3:0] PLIC_ENABLE  = 4'h4;
    localparam logic [3:0] PLIC_CLAIM   = 4'h8;

    // byte lanes of new_w replace those of old_w where be is set
    function automatic word_t merge_lanes(word_t old_w, word_t new_w, byte_en_t be);
        word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

endpackage

// File: design/platform_top.sv
`timescale 1ns/1ps

module platform_top #(
    parameter int IRQ_COUNT = 4,
    parameter int RAM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   bus_en_i,
    input  platform_pkg::byte_en_t bus_we_i,
    input  platform_pkg::addr_t    bus_addr_i,
    input  platform_pkg::word_t    bus_wdata_i,
    output platform_pkg::word_t    bus_rdata_o,
    input  logic [IRQ_COUNT-1:0]   irq_src_i,
    output logic [IRQ_COUNT-1:0]   irq_ack_o,
    output logic                   timer_irq_o,
    output logic                   ext_irq_o,
    output logic [63:0]            mtime_o
);

    data_bus_if ram_bus ();
    data_bus_if rtc_bus ();
    data_bus_if plic_bus ();

    //////////////////////////////
    // decode and slaves
    //////////////////////////////
    bus_decoder u_decoder (
        .clk         (clk),
        .reset_i     (reset_i),
        .bus_en_i    (bus_en_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .ram_bus     (ram_bus),
        .rtc_bus     (rtc_bus),
        .plic_bus    (plic_bus)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk (clk),
        .bus (ram_bus)
    );

    rtc u_rtc (
        .clk         (clk),
        .reset_i     (reset_i),
        .bus         (rtc_bus),
        .mtime_o     (mtime_o),
        .timer_irq_o (timer_irq_o)  // machine timer interrupt
    );

    plic #(
        .IRQ_COUNT (IRQ_COUNT)
    ) u_plic (
        .clk       (clk),
        .reset_i   (reset_i),
        .bus       (plic_bus),
        .irq_src_i (irq_src_i),
        .irq_ack_o (irq_ack_o),
        .ext_irq_o (ext_irq_o)      // machine external interrupt
    );

endmodule

// File: design/plic.sv
`timescale 1ns/1ps

module plic #(
    parameter int IRQ_COUNT = 4
) (
    input  logic                 clk,
    input  logic                 reset_i,
    data_bus_if.slave            bus,
    input  logic [IRQ_COUNT-1:0] irq_src_i,
    output logic [IRQ_COUNT-1:0] irq_ack_o,
    output logic                 ext_irq_o
);

    // bit i of each vector is source i+1, seen at word bit i+1
    logic [IRQ_COUNT-1:0] pending_q, enable_q, in_service_q;
    logic [IRQ_COUNT-1:0] active;
    logic [IRQ_COUNT-1:0] claim_hot, complete_hot;
    logic [4:0]           claim_id;
    logic [3:0]           offset;
    logic                 rd, wr;
    platform_pkg::word_t  pending_word, enable_word, enable_new;

    assign offset = {bus.addr[3:2], 2'b00};
    assign rd     = bus.en && (bus.we == '0);
    assign wr     = bus.en && (bus.we != '0);

    assign active    = pending_q & enable_q;
    assign ext_irq_o = |active;

    assign pending_word = platform_pkg::word_t'({pending_q, 1'b0});
    assign enable_word  = platform_pkg::word_t'({enable_q, 1'b0});
    assign enable_new   = platform_pkg::merge_lanes(enable_word, bus.wdata, bus.we);

    //////////////////////////////
    // claim / complete
    //////////////////////////////
    always_comb begin
        claim_id = '0;
        for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id = 5'(i + 1); // lowest number wins
            end
        end
    end

    // lowest set bit only
    assign claim_hot = (rd && offset == platform_pkg::PLIC_CLAIM) ?
                       (active & (~active + 1'b1)) : '0;

    always_comb begin
        for (int i = 0; i < IRQ_COUNT; i++) begin
            complete_hot[i] = wr && (offset == platform_pkg::PLIC_CLAIM) &&
                              (bus.wdata == 32'(i + 1));
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending_q    <= '0;
            enable_q     <= '0;
            in_service_q <= '0;
            irq_ack_o    <= '0;
        end else begin
            // sources in service are masked
            pending_q    <= (pending_q | (irq_src_i & ~in_service_q)) & ~claim_hot;
            in_service_q <= (in_service_q | claim_hot) & ~complete_hot;
            irq_ack_o    <= claim_hot; // one cycle pulse
            if (wr && offset == platform_pkg::PLIC_ENABLE) begin
                enable_q <= enable_new[IRQ_COUNT:1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.en) begin
            case (offset)
                platform_pkg::PLIC_PENDING: bus.rdata <= pending_word;
                platform_pkg::PLIC_ENABLE:  bus.rdata <= enable_word;
                platform_pkg::PLIC_CLAIM:   bus.rdata <= {27'b0, claim_id};
                default:                    bus.rdata <= '0;
            endcase
        end
    end

endmodule

// File: design/rtc.sv
`timescale 1ns/1ps

module rtc (
    input  logic        clk,
    input  logic        reset_i,
    data_bus_if.slave   bus,
    output logic [63:0] mtime_o,
    output logic        timer_irq_o
);

    logic [63:0] mtime_q, mtime_d;
    logic [63:0] mtimecmp_q, mtimecmp_d;
    logic [3:0]  offset;
    logic        wr;

    assign offset = {bus.addr[3:2], 2'b00};
    assign wr     = bus.en && (bus.we != '0);

    //////////////////////////////
    // next state
    //////////////////////////////
    always_comb begin
        mtime_d    = mtime_q + 64'd1; // counts through writes too
        mtimecmp_d = mtimecmp_q;
        if (wr) begin
            case (offset)
                platform_pkg::RTC_MTIME_LO: mtime_d[31:0] =
                    platform_pkg::merge_lanes(mtime_d[31:0], bus.wdata, bus.we);
                platform_pkg::RTC_MTIME_HI: mtime_d[63:32] =
                    platform_pkg::merge_lanes(mtime_d[63:32], bus.wdata, bus.we);
                platform_pkg::RTC_MTIMECMP_LO: mtimecmp_d[31:0] =
                    platform_pkg::merge_lanes(mtimecmp_q[31:0], bus.wdata, bus.we);
                default: mtimecmp_d[63:32] =
                    platform_pkg::merge_lanes(mtimecmp_q[63:32], bus.wdata, bus.we);
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1; // no timer irq until programmed
        end else begin
            mtime_q    <= mtime_d;
            mtimecmp_q <= mtimecmp_d;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.en) begin
            case (offset)
                platform_pkg::RTC_MTIME_LO:    bus.rdata <= mtime_q[31:0];
                platform_pkg::RTC_MTIME_HI:    bus.rdata <= mtime_q[63:32];
                platform_pkg::RTC_MTIMECMP_LO: bus.rdata <= mtimecmp_q[31:0];
                default:                       bus.rdata <= mtimecmp_q[63:32];
            endcase
        end
    end

    assign mtime_o     = mtime_q;
    assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module platform_tb -f sources.f -o platform_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/platform_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sources.f
design/platform_pkg.sv
design/data_bus_if.sv
design/bus_decoder.sv
design/data_ram.sv
design/rtc.sv
design/plic.sv
design/platform_top.sv
test/platform_chk.sv
test/platform_tb.sv

// File: test/platform_chk.sv
`timescale 1ns/1ps

module platform_chk #(
    parameter int IRQ_COUNT = 4
) (
    input logic                   clk,
    input logic                   reset_i,
    input logic                   bus_en_i,
    input platform_pkg::byte_en_t bus_we_i,
    input platform_pkg::addr_t    bus_addr_i,
    input platform_pkg::word_t    rdata_i,
    input logic [IRQ_COUNT-1:0]   irq_ack_i,
    input logic                   timer_irq_i,
    input logic                   ext_irq_i
);

    logic periph_rd;

    assign periph_rd = bus_en_i && (bus_we_i == '0) &&
                       (bus_addr_i[31:28] >= platform_pkg::PERIPH_REGION_START);

    // only the claimed source is acknowledged
    ack_one_hot: assert property (@(posedge clk) disable iff (reset_i) $onehot0(irq_ack_i))
        else $error("irq_ack_o has more than one bit set");

    irq_low_after_reset: assert property (@(posedge clk) reset_i |=> !ext_irq_i && !timer_irq_i)
        else $error("interrupt high in the cycle after reset");

    periph_reads_zero: assert property (@(posedge clk) disable iff (reset_i)
                                        periph_rd |=> rdata_i == '0)
        else $error("peripheral region read returned nonzero data");

endmodule

bind platform_top platform_chk #(
    .IRQ_COUNT (IRQ_COUNT)
) u_chk (
    .clk         (clk),
    .reset_i     (reset_i),
    .bus_en_i    (bus_en_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .rdata_i     (bus_rdata_o),
    .irq_ack_i   (irq_ack_o),
    .timer_irq_i (timer_irq_o),
    .ext_irq_i   (ext_irq_o)
);

// File: test/platform_tb.sv
`timescale 1ns/1ps

module platform_tb;

    localparam int    IRQ_COUNT  = 4;
    localparam int    RAM_WORDS  = 256;
    localparam string TESTS_FILE = "test/platform_tests.txt";

    logic                   clk;
    logic                   reset_i;
    logic                   bus_en_i;
    platform_pkg::byte_en_t bus_we_i;
    platform_pkg::addr_t    bus_addr_i;
    platform_pkg::word_t    bus_wdata_i;
    platform_pkg::word_t    bus_rdata_o;
    logic [IRQ_COUNT-1:0]   irq_src_i;
    logic [IRQ_COUNT-1:0]   irq_ack_o;
    logic                   timer_irq_o;
    logic                   ext_irq_o;
    logic [63:0]            mtime_o;

    int value_errors = 0;
    int file_errors  = 0;
    int cycle_count  = 0;
    int cycle_limit  = 100;    // raised once the tests file is counted

    logic                rd_pending = 1'b0;
    platform_pkg::addr_t rd_addr;
    platform_pkg::word_t rd_expect;
    logic [63:0]         mtime_model = '0;    // expected mtime, zero at reset release

    platform_top #(
        .IRQ_COUNT (IRQ_COUNT),
        .RAM_WORDS (RAM_WORDS)
    ) DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .bus_en_i    (bus_en_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .irq_src_i   (irq_src_i),
        .irq_ack_o   (irq_ack_o),
        .timer_irq_o (timer_irq_o),
        .ext_irq_o   (ext_irq_o),
        .mtime_o     (mtime_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_word(input platform_pkg::word_t got, input platform_pkg::word_t exp_w,
                              input platform_pkg::addr_t addr);
        if (got !== exp_w) begin
            $display("FAIL %0t: bus_rdata_o 0x%08h for 0x%08h, expected 0x%08h",
                     $time, got, addr, exp_w);
            value_errors++;
        end
    endtask

    task automatic check_irq(input logic [1:0] got, input logic [1:0] exp_bits);
        if (got !== exp_bits) begin
            $display("FAIL %0t: ext/timer irq %b, expected %b", $time, got, exp_bits);
            value_errors++;
        end
    endtask

    task automatic check_ack(input logic [IRQ_COUNT-1:0] got, input logic [IRQ_COUNT-1:0] exp_ack);
        if (got !== exp_ack) begin
            $display("FAIL %0t: irq_ack_o 0x%0h, expected 0x%0h", $time, got, exp_ack);
            value_errors++;
        end
    endtask

    task automatic check_mtime(input logic [63:0] got, input logic [63:0] exp_t);
        if (got !== exp_t) begin
            $display("FAIL %0t: mtime_o 0x%016h, expected 0x%016h", $time, got, exp_t);
            value_errors++;
        end
    endtask

    // mtime one edge on: counts up, a write to either half replaces its lanes
    function automatic logic [63:0] mtime_after_edge(input logic [63:0] cur);
        logic [63:0] nxt;
        int          base;
        nxt  = cur + 64'd1;
        base = bus_addr_i[2] ? 32 : 0;
        if (bus_en_i && bus_we_i != '0 && bus_addr_i[3] == 1'b0 &&
            bus_addr_i[31:28] == platform_pkg::RTC_REGION_START) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus_we_i[lane]) begin
                    nxt[base + lane*8 +: 8] = bus_wdata_i[lane*8 +: 8];
                end
            end
        end
        return nxt;
    endfunction

    // one clock, then the read issued before it is on bus_rdata_o
    task automatic step_cycle();
        @(posedge clk);
        mtime_model = mtime_after_edge(mtime_model);
        @(negedge clk);
        check_mtime(mtime_o, mtime_model);
        if (rd_pending) begin
            check_word(bus_rdata_o, rd_expect, rd_addr);
        end else begin
            check_word(bus_rdata_o, '0, bus_addr_i);    // no read, no data
        end
        rd_pending = 1'b0;
        bus_en_i   = 1'b0;
        bus_we_i   = '0;
    endtask

    //////////////////////////////
    // stimulus from the tests file
    //////////////////////////////
    initial begin
        int                     fd;
        int                     n;
        int                     line_count;
        int                     line_no;
        int                     idle;
        logic                   bad;
        logic [7:0]             op;
        logic [8*256-1:0]       line_buf;
        platform_pkg::addr_t    addr;
        platform_pkg::word_t    data;
        platform_pkg::byte_en_t be;
        logic [IRQ_COUNT-1:0]   pattern;
        logic                   ext_exp;
        logic                   timer_exp;

        reset_i     = 1'b1;
        bus_en_i    = 1'b0;
        bus_we_i    = '0;
        bus_addr_i  = '0;
        bus_wdata_i = '0;
        irq_src_i   = '0;
        line_count  = 0;
        line_no     = 0;

        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("could not open the tests file %s", TESTS_FILE);
            file_errors++;
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                line_count++;
            end
            $fclose(fd);
            fd = $fopen(TESTS_FILE, "r");   // second pass runs the operations
        end
        cycle_limit = line_count * 20 + 100;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        while (fd != 0 && !$feof(fd)) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                break;
            end
            line_no++;
            bad = 1'b0;
            case (op)
                "#": ;    // comment line
                "W": begin
                    n   = $fscanf(fd, " %h %h %h", addr, data, be);
                    bad = (n != 3);
                    if (!bad) begin
                        bus_en_i    = 1'b1;
                        bus_we_i    = be;
                        bus_addr_i  = addr;
                        bus_wdata_i = data;
                        step_cycle();
                    end
                end
                "R": begin
                    n   = $fscanf(fd, " %h %h", addr, data);
                    bad = (n != 2);
                    if (!bad) begin
                        bus_en_i   = 1'b1;
                        bus_we_i   = '0;
                        bus_addr_i = addr;
                        rd_addr    = addr;
                        rd_expect  = data;
                        rd_pending = 1'b1;
                        step_cycle();
                    end
                end
                "S": begin
                    n   = $fscanf(fd, " %h", pattern);
                    bad = (n != 1);
                    if (!bad) irq_src_i = pattern;
                end
                "C": begin
                    n   = $fscanf(fd, " %b %b", ext_exp, timer_exp);
                    bad = (n != 2);
                    if (!bad) check_irq({ext_irq_o, timer_irq_o}, {ext_exp, timer_exp});
                end
                "A": begin
                    n   = $fscanf(fd, " %h", pattern);
                    bad = (n != 1);
                    if (!bad) check_ack(irq_ack_o, pattern);
                end
                "N": begin
                    n   = $fscanf(fd, " %d", idle);
                    bad = (n != 1);
                    if (!bad) repeat (idle) step_cycle();
                end
                default: bad = 1'b1;
            endcase
            if (bad) begin
                $display("could not parse line %0d of %s", line_no, TESTS_FILE);
                file_errors++;
            end
            n = $fgets(line_buf, fd);   // drop the rest of the line
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("errors: %0d value, %0d file, %0d operations", value_errors, file_errors,
                 line_no);
        if (value_errors == 0 && file_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: test/platform_tests.txt
# op and fields, hex unless noted: W addr data be | R addr expect | S irq_src | A irq_ack
# C ext timer (bits) | N idle cycles (decimal); text after the fields is ignored
R 20000008 ffffffff    # mtimecmp after reset
R 2000000c ffffffff
C 0 0
W 00000010 11223344 f
W 00000014 aabbccdd f
W 00000010 000000ee 1  # low lane only
W 00000014 99550000 c  # two upper lanes
R 00000010 112233ee
R 00000014 9955ccdd
W 00000410 cafef00d 3  # aliases word 4 with 256 words
R 00000010 1122f00d
R 2000000c ffffffff    # back to back across regions
R 80000000 00000000
R 00000014 9955ccdd
R 8000fffc 00000000
R 00000410 1122f00d
W 20000004 00000000 f
W 20000000 00000100 f
R 20000000 00000100
R 20000000 00000101    # counter moved on
W 20000008 00000080 f
C 0 0
W 2000000c 00000000 f  # mtimecmp now below mtime
C 0 1
W 2000000c ffffffff f
C 0 0
S 6                    # sources 2 and 3, all disabled
N 2
R 30000000 0000000c
C 0 0
W 30000004 00000008 f  # enable source 3
C 1 0
W 30000004 0000000c f
R 30000008 00000002    # claim lowest
A 2
N 1
A 0
N 2
R 30000000 00000008    # source 2 held but in service
W 30000008 00000002 f  # complete
N 1
R 30000000 0000000c
S 0
R 30000008 00000002
A 2
R 30000008 00000003
A 4
C 0 0
R 30000008 00000000    # nothing left
A 0
